// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Everything OK

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/memChecker.sv ====
`timescale 1ns/100ps

module memChecker
    import memPkg::*;
#(
    parameter int RamAddrBits = 10
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   reqValid,
    input  memReqS req,
    input  logic   reqReady,
    input  logic   rspValid,
    input  memRspS rsp,
    input  addrT   fetchAddr,
    input  logic   fetchDone,
    input  dataT   fetchData,
    input  logic   testEnd,
    input  int     testNum,
    input  logic   allDone,
    output int     errorCount
);

    localparam int RamSize = 2**RamAddrBits;

    // Byte image of the RAM as the accepted stores leave it
    logic [7:0] model [RamSize];
    memRspS expected [$];

    int checks = 0;
    int errors = 0;
    int testChecks = 0;
    int testErrors = 0;

    assign errorCount = errors;

    function automatic int byteLen(lenE len);
        case (len)
            lenHalf: return 2;
            lenWord: return 4;
            default: return 1;
        endcase
    endfunction

    // Little-endian, zero above the access length
    function automatic dataT modelRead(addrT addr, int n);
        dataT word;
        addrT at;
        word = '0;
        for (int i = 0; i < n; i++) begin
            at = addr + addrT'(i);
            word[8*i +: 8] = model[at[RamAddrBits-1:0]];
        end
        return word;
    endfunction

    task automatic modelWrite(addrT addr, dataT data, int n);
        addrT at;
        for (int i = 0; i < n; i++) begin
            at = addr + addrT'(i);
            model[at[RamAddrBits-1:0]] = data[8*i +: 8];
        end
    endtask

    task automatic compare(string what, dataT got, dataT want, nickT gotNick, nickT wantNick);
        checks++;
        testChecks++;
        if (got !== want || gotNick !== wantNick) begin
            errors++;
            testErrors++;
            $display("FAIL %0t: %s data %h nick %0d, expected data %h nick %0d",
                     $time, what, got, gotNick, want, wantNick);
        end
    endtask

    // ############################################################
    // Sampling on the rising edge
    // ############################################################

    always @(posedge clk) begin
        memRspS want;
        if (!rst) begin
            // Responses first, they belong to older requests
            if (rspValid) begin
                if (expected.size() == 0) begin
                    errors++;
                    testErrors++;
                    $display("Response with nick %0d at %0t came with no request outstanding",
                             rsp.nick, $time);
                end else begin
                    want = expected.pop_front();
                    compare("response", rsp.data, want.data, rsp.nick, want.nick);
                end
            end
            if (reqValid && reqReady) begin
                want.nick = req.nick;
                if (req.store) begin
                    modelWrite(req.addr, req.data, byteLen(req.len));
                    want.data = '0;
                end else begin
                    want.data = modelRead(req.addr, byteLen(req.len));
                end
                expected.push_back(want);
            end
            if (fetchDone) begin
                compare("fetch", fetchData, modelRead(fetchAddr, 4), '0, '0);
            end
            if (testEnd) begin
                $display("Test %0d %s: %0d checks, %0d errors", testNum,
                         (testErrors == 0) ? "passed" : "FAILED", testChecks, testErrors);
                testChecks = 0;
                testErrors = 0;
            end
            if (allDone) begin
                if (expected.size() != 0) begin
                    errors++;
                    $display("%0d responses were never returned", expected.size());
                end
                $display("Totals: %0d checks, %0d errors", checks, errors);
            end
        end
    end

endmodule

// ==== dv/memSubsystemTb.sv ====
`timescale 1ns/100ps

module memSubsystemTb
    import memPkg::*;
();

    localparam int QueueDepth    = 4;
    localparam int RamAddrBits   = 10;
    localparam int ClkHalf       = 4;
    localparam int ResetCycles   = 5;
    localparam int DriveDelay    = 1;
    localparam int CyclesPerStep = 20;
    localparam int TimeoutSlack  = 100;
    localparam int BurstTest     = 3;

    localparam logic Store   = 1'b1;
    localparam logic Load    = 1'b0;
    localparam logic Fetch   = 1'b1;
    localparam logic NoFetch = 1'b0;

    typedef struct packed {
        logic [3:0] test;
        logic       store;
        addrT       addr;
        dataT       data;
        lenE        len;
        nickT       nick;
        logic       fetch;
        addrT       fetchAt;
    } stepS;

    logic   clk = 1'b0;
    logic   rst;
    logic   reqValid;
    memReqS req;
    logic   reqReady;
    logic   rspValid;
    memRspS rsp;
    logic   fetchEn;
    addrT   fetchAddr;
    logic   fetchDone;
    dataT   fetchData;

    logic testEnd;
    logic allDone;
    int   testNum;
    int   errorCount;

    stepS steps [$];
    addrT fetchList [$];
    int   seed = 71;
    int   timeoutLimit = 0;
    int   accepted = 0;
    int   rspSeen = 0;
    int   fetchServed = 0;
    int   burstStalls = 0;

    memSubsystem #(
        .QueueDepth  (QueueDepth),
        .RamAddrBits (RamAddrBits)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .reqValid  (reqValid),
        .req       (req),
        .reqReady  (reqReady),
        .rspValid  (rspValid),
        .rsp       (rsp),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchData (fetchData)
    );

    memChecker #(
        .RamAddrBits (RamAddrBits)
    ) chk (
        .clk        (clk),
        .rst        (rst),
        .reqValid   (reqValid),
        .req        (req),
        .reqReady   (reqReady),
        .rspValid   (rspValid),
        .rsp        (rsp),
        .fetchAddr  (fetchAddr),
        .fetchDone  (fetchDone),
        .fetchData  (fetchData),
        .testEnd    (testEnd),
        .testNum    (testNum),
        .allDone    (allDone),
        .errorCount (errorCount)
    );

    always #ClkHalf clk = ~clk;

    always @(posedge clk) begin
        if (!rst && rspValid) begin
            rspSeen <= rspSeen + 1;
        end
    end

    // ############################################################
    // Stimulus table
    // ############################################################

    task automatic addStep(int test, logic store, addrT addr, dataT data, lenE len,
                           nickT nick, logic fetch, addrT fetchAt);
        stepS s;
        s.test    = 4'(test);
        s.store   = store;
        s.addr    = addr;
        s.data    = data;
        s.len     = len;
        s.nick    = nick;
        s.fetch   = fetch;
        s.fetchAt = fetchAt;
        steps.push_back(s);
    endtask

    task automatic buildTable();
        addStep(1, Store, 32'h0000_0010, 32'hA1B2_C3D4, lenWord, 4'd1, NoFetch, '0);
        addStep(1, Load,  32'h0000_0010, '0, lenWord, 4'd2, NoFetch, '0);
        // Byte and half merges inside one word
        addStep(2, Store, 32'h0000_0040, 32'hFFFF_FF11, lenByte, 4'd3, NoFetch, '0);
        addStep(2, Store, 32'h0000_0041, 32'hFFFF_FF22, lenByte, 4'd4, NoFetch, '0);
        addStep(2, Store, 32'h0000_0042, 32'hFFFF_4433, lenHalf, 4'd5, NoFetch, '0);
        addStep(2, Load,  32'h0000_0040, '0, lenWord, 4'd6, NoFetch, '0);
        addStep(2, Store, 32'h0000_0050, 32'hDEAD_BEEF, lenWord, 4'd7, NoFetch, '0);
        addStep(2, Store, 32'h0000_0052, 32'h0000_005A, lenByte, 4'd8, NoFetch, '0);
        addStep(2, Load,  32'h0000_0050, '0, lenWord, 4'd9, NoFetch, '0);
        addStep(2, Load,  32'h0000_0053, '0, lenByte, 4'd10, NoFetch, '0);
        addStep(2, Load,  32'h0000_0051, '0, lenHalf, 4'd11, NoFetch, '0);
        // Burst deeper than the queue
        addStep(3, Store, 32'h0000_0100, $random(seed), lenWord, 4'd0, NoFetch, '0);
        addStep(3, Store, 32'h0000_0104, $random(seed), lenWord, 4'd1, NoFetch, '0);
        addStep(3, Store, 32'h0000_0108, $random(seed), lenWord, 4'd2, NoFetch, '0);
        addStep(3, Load,  32'h0000_0108, '0, lenWord, 4'd3, NoFetch, '0);
        addStep(3, Load,  32'h0000_0100, '0, lenWord, 4'd4, NoFetch, '0);
        addStep(3, Load,  32'h0000_0104, '0, lenWord, 4'd5, NoFetch, '0);
        addStep(4, Store, 32'h0000_0200, $random(seed), lenByte, 4'd12, NoFetch, '0);
        addStep(4, Store, 32'h0000_0202, $random(seed), lenHalf, 4'd13, NoFetch, '0);
        addStep(4, Store, 32'h0000_0204, $random(seed), lenWord, 4'd14, NoFetch, '0);
        addStep(4, Store, 32'h0000_0208, $random(seed), lenByte, 4'd15, NoFetch, '0);
        // Fetches only read words that no queued store touches
        addStep(5, Store, 32'h0000_0300, $random(seed), lenWord, 4'd1, Fetch, 32'h0000_0010);
        addStep(5, Load,  32'h0000_0300, '0, lenWord, 4'd2, Fetch, 32'h0000_0040);
        addStep(5, Store, 32'h0000_0304, $random(seed), lenHalf, 4'd3, Fetch, 32'h0000_0100);
        addStep(5, Load,  32'h0000_0304, '0, lenHalf, 4'd4, Fetch, 32'h0000_0204);
        addStep(5, Load,  32'h0000_0104, '0, lenWord, 4'd5, Fetch, 32'h0000_0050);
        addStep(6, Store, 32'h0000_1404, $random(seed), lenWord, 4'd6, NoFetch, '0);
        addStep(6, Load,  32'h0000_0004, '0, lenWord, 4'd7, NoFetch, '0);
        addStep(6, Store, 32'h0000_03FE, $random(seed), lenWord, 4'd8, Fetch, 32'h0000_0810);
        addStep(6, Load,  32'h0000_03FE, '0, lenWord, 4'd9, NoFetch, '0);
        addStep(6, Load,  32'h0000_0000, '0, lenHalf, 4'd10, NoFetch, '0);
        addStep(6, Load,  32'hFFFF_FFFF, '0, lenByte, 4'd11, NoFetch, '0);
    endtask

    // ############################################################
    // Driving
    // ############################################################

    task automatic applyStep(stepS s);
        reqValid  = 1'b1;
        req.store = s.store;
        req.addr  = s.addr;
        req.data  = s.data;
        req.len   = s.len;
        req.nick  = s.nick;
        if (s.fetch) begin
            fetchList.push_back(s.fetchAt);
        end
        do begin
            @(posedge clk);
            if (!reqReady && s.test == 4'(BurstTest)) begin
                burstStalls++;
            end
        end while (!reqReady);
        accepted++;
        #DriveDelay;
        reqValid = 1'b0;
    endtask

    // Drain both sides, then let the checker close the test
    task automatic finishTest();
        while (rspSeen != accepted || fetchServed != fetchList.size()) begin
            @(posedge clk);
            #DriveDelay;
        end
        testEnd = 1'b1;
        @(posedge clk);
        #DriveDelay;
        testEnd = 1'b0;
    endtask

    initial begin : fetchDriver
        fetchEn   = 1'b0;
        fetchAddr = '0;
        forever begin
            @(posedge clk);
            if (fetchEn && fetchDone) begin
                fetchServed++;
                #DriveDelay;
                fetchEn = 1'b0;
            end else if (!fetchEn && fetchServed < fetchList.size()) begin
                #DriveDelay;
                fetchEn   = 1'b1;
                fetchAddr = fetchList[fetchServed];
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (cycles < timeoutLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
        $display("Something failed");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        reqValid = 1'b0;
        req      = '0;
        testEnd  = 1'b0;
        allDone  = 1'b0;
        testNum  = 0;
        buildTable();
        timeoutLimit = steps.size() * CyclesPerStep + TimeoutSlack;
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        rst     = 1'b0;
        testNum = steps[0].test;
        foreach (steps[i]) begin
            if (steps[i].test != testNum) begin
                finishTest();
                testNum = steps[i].test;
            end
            applyStep(steps[i]);
        end
        finishTest();
        allDone = 1'b1;
        @(posedge clk);
        #DriveDelay;
        allDone = 1'b0;
        if (burstStalls == 0) begin
            $display("Burst test never saw reqReady low, back-pressure went unchecked");
        end
        if (errorCount == 0 && burstStalls != 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== source/byteRam.sv ====
`timescale 1ns/100ps

module byteRam #(
    parameter int RamAddrBits = 10
) (
    input  logic                   clk,
    input  logic                   ramEn,
    input  logic                   ramWe,
    input  logic [RamAddrBits-1:0] ramAddr,
    input  logic [7:0]             ramWdata,
    output logic [7:0]             ramRdata
);

    logic [7:0] mem [2**RamAddrBits];

    // Single port, read data registered
    always_ff @(posedge clk) begin
        if (ramEn) begin
            if (ramWe) begin
                mem[ramAddr] <= ramWdata;
            end else begin
                ramRdata <= mem[ramAddr];
            end
        end
    end

endmodule

// ==== source/dataPort.sv ====
`timescale 1ns/100ps

module dataPort
    import memPkg::*;
(
    input  logic   clk,
    input  logic   rst,

    output logic   slotFree,
    input  logic   issueValid,
    input  memReqS issue,

    output logic   doneValid,
    output memRspS done,

    output logic   memEn,
    output memReqS memReq,
    input  logic   dataBusy,
    input  logic   memDone,
    input  dataT   memData
);

    logic   occupied;
    memReqS slot;

    assign slotFree = !occupied;

    // Hold the access while the controller is away on something else
    assign memEn  = occupied && !dataBusy;
    assign memReq = slot;

    // ############################################################
    // Slot control
    // ############################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied  <= 1'b0;
            doneValid <= 1'b0;
        end else begin
            doneValid <= memDone;
            if (memDone) begin
                occupied <= 1'b0;
            end
            if (issueValid) begin
                occupied <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            slot <= issue;
        end
        if (memDone) begin
            done.data <= memData;
            done.nick <= slot.nick;  // nick saved with the access
        end
    end

    // The queue only issues into an empty slot
    assert property (@(posedge clk) disable iff (rst) issueValid |-> !occupied);

endmodule

// ==== source/loadStoreQueue.sv ====
`timescale 1ns/100ps

module loadStoreQueue
    import memPkg::*;
#(
    parameter int QueueDepth = 4
) (
    input  logic   clk,
    input  logic   rst,

    input  logic   reqValid,
    input  memReqS req,
    output logic   reqReady,

    output logic   rspValid,
    output memRspS rsp,

    input  logic   slotFree,
    output logic   issueValid,
    output memReqS issue,

    input  logic   doneValid,
    input  memRspS done
);

    localparam int PtrBits = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CountBits = $clog2(QueueDepth + 1);

    memReqS entries [QueueDepth];

    logic [PtrBits-1:0] wrPtr;
    logic [PtrBits-1:0] rdPtr;
    logic [CountBits-1:0] count;
    logic inFlight;

    logic push;
    logic pop;

    assign reqReady = (count != CountBits'(QueueDepth));
    assign push     = reqValid && reqReady;

    // Issue the head once the slot has been seen free, one access at a time
    assign pop = slotFree && !issueValid && (count != '0);

    // Completions come back in order, so they pass straight through
    assign rspValid = doneValid;
    assign rsp      = done;

    // ############################################################
    // Pointers and fill level
    // ############################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                if (wrPtr == PtrBits'(QueueDepth - 1)) begin
                    wrPtr <= '0;
                end else begin
                    wrPtr <= wrPtr + 1'b1;
                end
            end
            if (pop) begin
                if (rdPtr == PtrBits'(QueueDepth - 1)) begin
                    rdPtr <= '0;
                end else begin
                    rdPtr <= rdPtr + 1'b1;
                end
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= req;
        end
        if (pop) begin
            issue <= entries[rdPtr];
        end
    end

    // ############################################################
    // Issue handshake and in-flight tracking
    // ############################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            issueValid <= 1'b0;
            inFlight   <= 1'b0;
        end else begin
            issueValid <= pop;
            if (issueValid) begin
                inFlight <= 1'b1;
            end else if (doneValid) begin
                inFlight <= 1'b0;
            end
        end
    end

    // A push must never land on the oldest entry still waiting to issue
    assert property (@(posedge clk) disable iff (rst)
        push |-> (count == '0 || wrPtr != rdPtr));

    // A completion must belong to an access handed to the data port
    assert property (@(posedge clk) disable iff (rst) doneValid |-> inFlight);

endmodule

// ==== source/memCtrl.sv ====
`timescale 1ns/100ps

module memCtrl
    import memPkg::*;
#(
    parameter int RamAddrBits = 10
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   fetchEn,
    input  addrT                   fetchAddr,
    output logic                   fetchDone,
    output dataT                   fetchData,

    input  logic                   memEn,
    input  memReqS                 memReq,
    output logic                   dataBusy,
    output logic                   memDone,
    output dataT                   memData,

    output logic                   ramEn,
    output logic                   ramWe,
    output logic [RamAddrBits-1:0] ramAddr,
    output logic [7:0]             ramWdata,
    input  logic [7:0]             ramRdata
);

    ctrlStateE state;

    // Counts issued bytes, then one extra cycle for the last read byte
    logic [2:0] cnt;
    logic [2:0] total;
    logic [1:0] prevIdx;
    logic lastData;
    logic grantFetch;
    logic busy;

    logic curStore;
    addrT curAddr;
    dataT curData;
    lenE  curLen;
    dataT assembled;
    dataT merged;

    function automatic logic [2:0] byteCount(lenE len);
        case (len)
            lenHalf: byteCount = 3'd2;
            lenWord: byteCount = 3'd4;
            default: byteCount = 3'd1;
        endcase
    endfunction

    // Alternate when both sides wait
    assign grantFetch = fetchEn && (!memEn || lastData);

    assign busy     = (state != idle);
    assign dataBusy = busy;
    assign total    = byteCount(curLen);
    assign prevIdx  = cnt[1:0] - 2'd1;

    // ############################################################
    // Arbitration and byte sequencing
    // ############################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            cnt      <= '0;
            lastData <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    cnt <= '0;
                    if (grantFetch) begin
                        state    <= fetchBusy;
                        lastData <= 1'b0;
                    end else if (memEn) begin
                        state    <= memPkg::dataBusy;
                        lastData <= 1'b1;
                    end
                end
                default: begin
                    if (cnt == total) begin
                        state <= idle;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
            endcase
        end
    end

    // Latch the granted access
    always_ff @(posedge clk) begin
        if (state == idle) begin
            assembled <= '0;
            if (grantFetch) begin
                curStore <= 1'b0;
                curAddr  <= fetchAddr;
                curData  <= '0;
                curLen   <= lenWord;
            end else begin
                curStore <= memReq.store;
                curAddr  <= memReq.addr;
                curData  <= memReq.data;
                curLen   <= memReq.len;
            end
        end else begin
            assembled <= merged;
        end
    end

    // Read data trails its address by a cycle and lands little-endian
    always_comb begin
        merged = assembled;
        if (busy && cnt != 3'd0 && !curStore) begin
            merged[{prevIdx, 3'b000} +: 8] = ramRdata;
        end
    end

    // ############################################################
    // RAM side and completions
    // ############################################################

    assign ramEn    = busy && (cnt < total);
    assign ramWe    = ramEn && curStore;
    assign ramAddr  = curAddr[RamAddrBits-1:0] + RamAddrBits'(cnt);
    assign ramWdata = curData[{cnt[1:0], 3'b000} +: 8];

    assign memDone   = (state == memPkg::dataBusy) && (cnt == total);
    assign memData   = merged;
    assign fetchDone = (state == fetchBusy) && (cnt == total);
    assign fetchData = merged;

    assert property (@(posedge clk) disable iff (rst) !(memDone && fetchDone));

endmodule

// ==== source/memPkg.sv ====
package memPkg;

    // ############################################################
    // Widths with a meaning
    // ############################################################

    // Byte address, wraps modulo the RAM size downstream
    typedef logic [31:0] addrT;

    typedef logic [31:0] dataT;

    // Tag picked by the requester and echoed back in the response
    typedef logic [3:0] nickT;

    typedef enum logic [1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd2
    } lenE;

    // ############################################################
    // Request and response
    // ############################################################

    typedef struct packed {
        logic store;
        addrT addr;
        dataT data;
        lenE  len;
        nickT nick;
    } memReqS;

    // Loads carry zero-extended data, stores carry zero
    typedef struct packed {
        dataT data;
        nickT nick;
    } memRspS;

    // ############################################################
    // State machines
    // ############################################################

    typedef enum logic [1:0] {
        idle      = 2'd0,
        fetchBusy = 2'd1,
        dataBusy  = 2'd2
    } ctrlStateE;

endpackage

// ==== source/memSubsystem.sv ====
`timescale 1ns/100ps

module memSubsystem
    import memPkg::*;
#(
    parameter int QueueDepth  = 4,
    parameter int RamAddrBits = 10
) (
    input  logic   clk,
    input  logic   rst,

    input  logic   reqValid,
    input  memReqS req,
    output logic   reqReady,

    output logic   rspValid,
    output memRspS rsp,

    input  logic   fetchEn,
    input  addrT   fetchAddr,
    output logic   fetchDone,
    output dataT   fetchData
);

    // ############################################################
    // Queue to data port
    // ############################################################

    logic   slotFree;
    logic   issueValid;
    memReqS issue;
    logic   doneValid;
    memRspS done;

    // ############################################################
    // Data port to controller to RAM
    // ############################################################

    logic   memEn;
    memReqS memReq;
    logic   dataBusy;
    logic   memDone;
    dataT   memData;

    logic                   ramEn;
    logic                   ramWe;
    logic [RamAddrBits-1:0] ramAddr;
    logic [7:0]             ramWdata;
    logic [7:0]             ramRdata;

    loadStoreQueue #(
        .QueueDepth (QueueDepth)
    ) lsq (
        .clk        (clk),
        .rst        (rst),
        .reqValid   (reqValid),
        .req        (req),
        .reqReady   (reqReady),
        .rspValid   (rspValid),
        .rsp        (rsp),
        .slotFree   (slotFree),
        .issueValid (issueValid),
        .issue      (issue),
        .doneValid  (doneValid),
        .done       (done)
    );

    dataPort port (
        .clk        (clk),
        .rst        (rst),
        .slotFree   (slotFree),
        .issueValid (issueValid),
        .issue      (issue),
        .doneValid  (doneValid),
        .done       (done),
        .memEn      (memEn),
        .memReq     (memReq),
        .dataBusy   (dataBusy),
        .memDone    (memDone),
        .memData    (memData)
    );

    memCtrl #(
        .RamAddrBits (RamAddrBits)
    ) ctrl (
        .clk       (clk),
        .rst       (rst),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchData (fetchData),
        .memEn     (memEn),
        .memReq    (memReq),
        .dataBusy  (dataBusy),
        .memDone   (memDone),
        .memData   (memData),
        .ramEn     (ramEn),
        .ramWe     (ramWe),
        .ramAddr   (ramAddr),
        .ramWdata  (ramWdata),
        .ramRdata  (ramRdata)
    );

    byteRam #(
        .RamAddrBits (RamAddrBits)
    ) ram (
        .clk      (clk),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

endmodule

// ==== tb.f ====
source/memPkg.sv
source/loadStoreQueue.sv
source/dataPort.sv
source/memCtrl.sv
source/byteRam.sv
source/memSubsystem.sv
dv/memChecker.sv
dv/memSubsystemTb.sv
